// File: verilog.f
src/decode_pkg.sv
src/thread_number.sv
src/ram_sdp.sv
src/credit_fifo.sv
src/credit_tx.sv
src/opcode_decoder.sv
src/decode_stage_top.sv
bench/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it.
# The run counts as passed only if the pass message appears in the output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_decode_stage \
    -o sim_decode_stage

status=0
output=$(./obj_dir/sim_decode_stage) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

// File: bench/tb_decode_stage.sv
// Testbench for the decode stage top level.
// Programs the opcode table, streams instructions through the input credit
// interface and checks every decoded output with concurrent assertions.

`timescale 1ns/1ns

module tb_decode_stage;

    localparam int thread_count = 4;
    localparam int in_depth     = 4;
    localparam int out_credits  = 3;
    localparam int wait_limit   = 200;

    logic                     clock = 1'b0;
    logic                     rst_n;
    logic                     in_valid;
    decode_pkg::instr_t       in_instr;
    logic                     in_credit;
    logic                     table_write_valid;
    decode_pkg::table_write_t table_write;
    logic                     out_valid;
    decode_pkg::decoded_t     out_data;
    logic                     out_credit = 1'b0;

    // Reference table, indexed by {thread, opcode} like the DUT's own
    logic [decode_pkg::control_width-1:0] model_table [64];
    decode_pkg::decoded_t                 expected_mem [256];
    decode_pkg::decoded_t                 expected_head;
    logic [7:0]  expected_count = '0;
    logic [7:0]  checked;
    logic [7:0]  returned = '0;
    int          sent = 0;
    int          credit_pulses;
    logic        consumer_on = 1'b0;
    logic        quiet_window;
    logic [31:0] rng_state = 32'h4166c509;
    string       test_name = "none";
    int          errors = 0;
    int          timeouts = 0;
    int          tests_run = 0;
    int          test_start = 0;

    decode_stage_top #(
        .thread_count (thread_count),
        .in_depth     (in_depth),
        .out_credits  (out_credits)
    ) DUT (
        .clock             (clock),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_instr          (in_instr),
        .in_credit         (in_credit),
        .table_write_valid (table_write_valid),
        .table_write       (table_write),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_credit        (out_credit)
    );

    always #10 clock = ~clock;

    // ----------------------------------------------------------------------
    // Output tracking and consumer
    // ----------------------------------------------------------------------

    assign expected_head = expected_mem[checked];

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            checked       <= '0;
            credit_pulses <= 0;
        end else begin
            if (out_valid) begin
                checked <= checked + 8'd1;
            end
            if (in_credit) begin
                credit_pulses <= credit_pulses + 1;
            end
        end
    end

    // Hands back one slot per cycle for every output it is holding
    always @(negedge clock) begin
        if (consumer_on && returned != checked) begin
            out_credit <= 1'b1;
            returned   <= returned + 8'd1;
        end else begin
            out_credit <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    reset_quiet : assert property (
        @(negedge clock) quiet_window |-> (!out_valid && !in_credit)
    ) else begin
        $display("error %s: out_valid/in_credit expected 0/0, actual %b/%b", test_name,
                 $sampled(out_valid), $sampled(in_credit));
        errors++;
    end

    no_stray_output : assert property (
        @(negedge clock) disable iff (!rst_n) out_valid |-> (checked < expected_count)
    ) else begin
        $display("error %s: out_valid rose with no instruction pending", test_name);
        errors++;
    end

    thread_match : assert property (
        @(negedge clock) disable iff (!rst_n)
        out_valid |-> (out_data.thread == expected_head.thread)
    ) else begin
        $display("error %s: thread expected %0d, actual %0d", test_name,
                 $sampled(expected_head.thread), $sampled(out_data.thread));
        errors++;
    end

    control_match : assert property (
        @(negedge clock) disable iff (!rst_n)
        out_valid |-> (out_data.control == expected_head.control)
    ) else begin
        $display("error %s: control expected %h, actual %h", test_name,
                 $sampled(expected_head.control), $sampled(out_data.control));
        errors++;
    end

    operand_match : assert property (
        @(negedge clock) disable iff (!rst_n)
        out_valid |-> (out_data.operand == expected_head.operand)
    ) else begin
        $display("error %s: operand expected %h, actual %h", test_name,
                 $sampled(expected_head.operand), $sampled(out_data.operand));
        errors++;
    end

    // Outputs held by the consumer can never outnumber its buffer slots
    consumer_space : assert property (
        @(negedge clock) disable iff (!rst_n)
        ((checked - returned) + 8'(out_valid)) <= 8'(out_credits)
    ) else begin
        $display("error %s: more outputs arrived than the consumer has room for", test_name);
        errors++;
    end

    input_credit_bound : assert property (
        @(negedge clock) disable iff (!rst_n) credit_pulses <= sent
    ) else begin
        $display("error %s: in_credit returned more credits than were spent", test_name);
        errors++;
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers entered and left on a falling edge
    // ----------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic program_entry(input logic [decode_pkg::thread_width-1:0] thread,
                                 input logic [decode_pkg::opcode_width-1:0] opcode,
                                 input logic [decode_pkg::control_width-1:0] control);
        table_write_valid = 1'b1;
        table_write = '{thread: thread, opcode: opcode, control: control};
        model_table[{thread, opcode}] = control;
        @(negedge clock);
        table_write_valid = 1'b0;
    endtask

    // Instruction k goes to thread k modulo thread_count
    task automatic send_instr(input logic [decode_pkg::opcode_width-1:0] opcode,
                              input logic [decode_pkg::operand_width-1:0] operand);
        int                                  waited;
        logic [decode_pkg::thread_width-1:0] thread;
        waited = 0;
        while (in_depth - (sent - credit_pulses) <= 0 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (in_depth - (sent - credit_pulses) <= 0) begin
            $display("timeout in %s: the sender never got an input credit", test_name);
            timeouts++;
        end else begin
            thread = decode_pkg::thread_width'(sent % thread_count);
            in_valid = 1'b1;
            in_instr = '{opcode: opcode, operand: operand};
            expected_mem[expected_count] = '{thread: thread,
                                             control: model_table[{thread, opcode}],
                                             operand: operand};
            expected_count = expected_count + 8'd1;
            sent++;
            @(negedge clock);
            in_valid = 1'b0;
        end
    endtask

    task automatic send_random();
        logic [31:0] r;
        r = next_random();
        send_instr(r[3:0], r[31:20]);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((checked != expected_count || returned != checked) && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        if (checked != expected_count || returned != checked) begin
            $display("timeout in %s: outputs or credits did not drain", test_name);
            timeouts++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_start = errors + timeouts;
    endtask

    task automatic end_test();
        int failures;
        failures = errors + timeouts - test_start;
        tests_run++;
        if (failures == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d failures", test_name, failures);
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        logic [7:0]  out_start;
        int          pulse_start;
        rst_n             = 1'b0;
        quiet_window      = 1'b1;
        in_valid          = 1'b0;
        in_instr          = '0;
        table_write_valid = 1'b0;
        table_write       = '0;

        begin_test("reset_state");
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        quiet_window = 1'b0;
        consumer_on  = 1'b1;
        @(negedge clock);
        end_test();

        begin_test("table_decode");
        for (int t = 0; t < thread_count; t++) begin
            for (int op = 0; op < 16; op++) begin
                r = next_random();
                program_entry(decode_pkg::thread_width'(t), decode_pkg::opcode_width'(op),
                              r[15:0]);
            end
        end
        for (int i = 0; i < 32; i++) begin
            send_random();
        end
        wait_idle();
        end_test();

        // Low bits carry the thread so all four entries surely differ
        begin_test("thread_rotation");
        r = next_random();
        for (int t = 0; t < thread_count; t++) begin
            program_entry(decode_pkg::thread_width'(t), 4'ha,
                          {r[15:2], decode_pkg::thread_width'(t)});
        end
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            send_instr(4'ha, r[11:0]);
        end
        wait_idle();
        end_test();

        begin_test("table_reprogram");
        program_entry(2'd2, 4'h5, ~model_table[{2'd2, 4'h5}]);
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            send_instr(4'h5, r[11:0]);
        end
        wait_idle();
        end_test();

        begin_test("back_pressure");
        consumer_on = 1'b0;
        out_start   = checked;
        pulse_start = credit_pulses;
        for (int i = 0; i < in_depth + out_credits; i++) begin
            send_random();
        end
        repeat (12) @(negedge clock);
        assert (int'(checked - out_start) == out_credits) else begin
            $display("error %s: outputs expected %0d, actual %0d", test_name,
                     out_credits, int'(checked - out_start));
            errors++;
        end
        assert (credit_pulses - pulse_start == out_credits) else begin
            $display("error %s: in_credit pulses expected %0d, actual %0d", test_name,
                     out_credits, credit_pulses - pulse_start);
            errors++;
        end
        consumer_on = 1'b1;
        wait_idle();
        end_test();

        begin_test("credit_conservation");
        pulse_start = credit_pulses;
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            repeat (r[1:0]) @(negedge clock);
            send_random();
        end
        wait_idle();
        assert (credit_pulses - pulse_start == 40) else begin
            $display("error %s: in_credit pulses expected 40, actual %0d", test_name,
                     credit_pulses - pulse_start);
            errors++;
        end
        end_test();

        $display("%0d tests run, %0d check errors, %0d timeouts", tests_run, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src/decode_stage_top.sv
// Decode stage of the barrel processor front end.
// Connects the credit-returning input buffer, the opcode decoder and the
// output credit counter, and passes the sizing parameters down to them.

`timescale 1ns/1ns

module decode_stage_top #(
    parameter int thread_count = 4,
    parameter int in_depth     = 4,
    parameter int out_credits  = 3
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  decode_pkg::instr_t       in_instr,
    output logic                     in_credit,
    input  logic                     table_write_valid,
    input  decode_pkg::table_write_t table_write,
    output logic                     out_valid,
    output decode_pkg::decoded_t     out_data,
    input  logic                     out_credit
);

    decode_pkg::instr_t head_instr;
    logic               buffer_empty;
    logic               issue;
    logic               out_ready;

    // ----------------------------------------------------------------------
    // Input buffer
    // ----------------------------------------------------------------------

    credit_fifo #(
        .payload_t (decode_pkg::instr_t),
        .depth     (in_depth)
    ) u_input_buffer (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_instr),
        .pop       (issue),
        .pop_data  (head_instr),
        .empty     (buffer_empty),
        .credit    (in_credit)
    );

    // ----------------------------------------------------------------------
    // Decoder
    // ----------------------------------------------------------------------

    opcode_decoder #(
        .thread_count (thread_count)
    ) u_decoder (
        .clock             (clock),
        .rst_n             (rst_n),
        .instr             (head_instr),
        .instr_empty       (buffer_empty),
        .out_ready         (out_ready),
        .instr_pop         (issue),
        .table_write_valid (table_write_valid),
        .table_write       (table_write),
        .out_valid         (out_valid),
        .out_data          (out_data)
    );

    // ----------------------------------------------------------------------
    // Output credits
    // ----------------------------------------------------------------------

    credit_tx #(
        .credits (out_credits)
    ) u_output_credits (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue         (issue),
        .credit_return (out_credit),
        .ready         (out_ready)
    );

endmodule

// File: src/opcode_decoder.sv
// Issue control and per-thread opcode table lookup.
// The current thread and the opcode together address the table, and the
// thread and operand are held for one cycle to line up with the table read.

`timescale 1ns/1ns

module opcode_decoder #(
    parameter int thread_count = 4
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  decode_pkg::instr_t       instr,
    input  logic                     instr_empty,
    input  logic                     out_ready,
    output logic                     instr_pop,
    input  logic                     table_write_valid,
    input  decode_pkg::table_write_t table_write,
    output logic                     out_valid,
    output decode_pkg::decoded_t     out_data
);

    localparam int table_addr_width = decode_pkg::thread_width + decode_pkg::opcode_width;
    localparam int table_depth      = thread_count * (2 ** decode_pkg::opcode_width);

    logic [decode_pkg::thread_width-1:0]  current_thread;
    logic [table_addr_width-1:0]          read_addr;
    logic [table_addr_width-1:0]          write_addr;
    logic [decode_pkg::control_width-1:0] control;
    logic [decode_pkg::thread_width-1:0]  thread_q;
    logic [decode_pkg::operand_width-1:0] operand_q;

    // ----------------------------------------------------------------------
    // Issue and thread slot
    // ----------------------------------------------------------------------

    // Issue needs a waiting instruction and a reserved slot downstream
    assign instr_pop = !instr_empty && out_ready;

    thread_number #(
        .thread_count (thread_count)
    ) u_thread_number (
        .clock          (clock),
        .rst_n          (rst_n),
        .advance        (instr_pop),
        .current_thread (current_thread)
    );

    // ----------------------------------------------------------------------
    // Opcode table
    // ----------------------------------------------------------------------

    // Thread in the upper bits gives each thread its own block of opcodes
    assign read_addr  = {current_thread, instr.opcode};
    assign write_addr = {table_write.thread, table_write.opcode};

    ram_sdp #(
        .addr_width (table_addr_width),
        .depth      (table_depth)
    ) u_opcode_table (
        .clock      (clock),
        .wren       (table_write_valid),
        .write_addr (write_addr),
        .write_data (table_write.control),
        .rden       (instr_pop),
        .read_addr  (read_addr),
        .read_data  (control)
    );

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= instr_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (instr_pop) begin
            thread_q  <= current_thread;
            operand_q <= instr.operand;
        end
    end

    assign out_data = '{thread: thread_q, control: control, operand: operand_q};

    // A write to a thread that does not exist would land outside the table
    a_table_write_thread : assert property (
        @(posedge clock) disable iff (!rst_n)
        table_write_valid |-> (int'(table_write.thread) < thread_count)
    );

endmodule

// File: src/credit_tx.sv
// Output-side credit counter tracking free slots in the consumer's buffer.
// A credit is spent when an instruction issues, so the item in flight
// always has room waiting when it reaches the output.

`timescale 1ns/1ns

module credit_tx #(
    parameter int credits = 3
) (
    input  logic clock,
    input  logic rst_n,
    input  logic issue,
    input  logic credit_return,
    output logic ready
);

    localparam int count_width = $clog2(credits + 1);

    localparam logic [count_width-1:0] max_count = count_width'(credits);

    logic [count_width-1:0] count;

    // ----------------------------------------------------------------------
    // Credit count
    // ----------------------------------------------------------------------

    // Issue and return in the same cycle cancel out
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= max_count;
        end else begin
            case ({issue, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign ready = (count != '0);

    // The decoder must only issue while a credit is held
    a_no_issue_without_credit : assert property (
        @(posedge clock) disable iff (!rst_n) !(issue && count == '0)
    );

    // The consumer can never hand back more credits than it was given
    a_no_excess_return : assert property (
        @(posedge clock) disable iff (!rst_n)
        (credit_return && !issue) |-> (count < max_count)
    );

endmodule

// File: src/credit_fifo.sv
// Input buffer that hands one credit back to the sender for every entry it pops.
// The head entry is always visible on pop_data, and the payload type is a
// parameter so the same buffer can carry any packed struct.

`timescale 1ns/1ns

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     credit
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    localparam logic [ptr_width-1:0]   last_slot = ptr_width'(depth - 1);
    localparam logic [count_width-1:0] full_fill = count_width'(depth);

    payload_t               mem [depth];
    logic [ptr_width-1:0]   write_ptr;
    logic [ptr_width-1:0]   read_ptr;
    logic [count_width-1:0] fill;
    logic                   full;

    // ----------------------------------------------------------------------
    // Pointers and fill count
    // ----------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            fill      <= '0;
        end else begin
            if (push) begin
                write_ptr <= (write_ptr == last_slot) ? '0 : write_ptr + 1'b1;
            end
            if (pop) begin
                read_ptr <= (read_ptr == last_slot) ? '0 : read_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[write_ptr] <= push_data;
        end
    end

    assign pop_data = mem[read_ptr];
    assign empty    = (fill == '0);
    assign full     = (fill == full_fill);

    // A popped entry frees a slot, so the sender gets its credit back at once
    assign credit = pop;

    // The sender's credit count should make both of these impossible
    a_no_push_when_full : assert property (
        @(posedge clock) disable iff (!rst_n) !(push && full)
    );

    a_no_pop_when_empty : assert property (
        @(posedge clock) disable iff (!rst_n) !(pop && empty)
    );

endmodule

// File: src/ram_sdp.sv
// Simple dual-port memory holding the opcode table.
// One write port and one registered read port, with old data returned
// when a read and a write hit the same address in the same cycle.

`timescale 1ns/1ns

module ram_sdp #(
    parameter int addr_width = 6,
    parameter int depth      = 64
) (
    input  logic                                 clock,
    input  logic                                 wren,
    input  logic [addr_width-1:0]                write_addr,
    input  logic [decode_pkg::control_width-1:0] write_data,
    input  logic                                 rden,
    input  logic [addr_width-1:0]                read_addr,
    output logic [decode_pkg::control_width-1:0] read_data
);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    logic [decode_pkg::control_width-1:0] mem [depth];

    // Contents are only meaningful after the host has written them
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------

    // Both blocks sample mem before the edge updates it, so a colliding
    // read sees the value from before the write
    always_ff @(posedge clock) begin
        if (rden) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

// File: src/thread_number.sv
// Round-robin thread slot counter for the barrel front end.
// It steps once per issued instruction and wraps after the last thread.

`timescale 1ns/1ns

module thread_number #(
    parameter int thread_count = 4
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              advance,
    output logic [decode_pkg::thread_width-1:0] current_thread
);

    localparam logic [decode_pkg::thread_width-1:0] last_thread =
        decode_pkg::thread_width'(thread_count - 1);

    // The first instruction after reset belongs to thread 0
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            current_thread <= '0;
        end else if (advance) begin
            if (current_thread == last_thread) begin
                current_thread <= '0;
            end else begin
                current_thread <= current_thread + 1'b1;
            end
        end
    end

endmodule

// File: src/decode_pkg.sv
// Shared field widths and packed structs for the instruction decode stage.
// RTL and testbench files refer to these by scoped name.

package decode_pkg;

    // ----------------------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------------------

    localparam int opcode_width  = 4;
    localparam int operand_width = 12;
    localparam int control_width = 16;

    // Two bits are enough for the four threads of the barrel
    localparam int thread_width  = 2;

    // ----------------------------------------------------------------------
    // Payload structs
    // ----------------------------------------------------------------------

    // One instruction as it leaves the fetch side, 16 bits
    typedef struct packed {
        logic [opcode_width-1:0]  opcode;
        logic [operand_width-1:0] operand;
    } instr_t;

    // Host write into the opcode table, 22 bits
    // The thread travels with the write so any thread can be programmed at any time
    typedef struct packed {
        logic [thread_width-1:0]  thread;
        logic [opcode_width-1:0]  opcode;
        logic [control_width-1:0] control;
    } table_write_t;

    // Decoded instruction handed to the consumer, 30 bits
    typedef struct packed {
        logic [thread_width-1:0]  thread;
        logic [control_width-1:0] control;
        logic [operand_width-1:0] operand;
    } decoded_t;

endpackage
